/* bench/armControlBench.sv */
`timescale 1ns/10ps

module armControlBench import controlPkg::*; ();

	localparam int NumTests = 6;
	localparam int InstrPerTest = 40;
	localparam int TimeoutCycles = NumTests * InstrPerTest * 16 + 100;

	logic clk;
	logic reset;
	logic [InstrWidth-1:0] memData;
	logic moc;
	logic [3:0] flags;
	logic memRequest;
	logic memWrite;
	logic memByte;
	logic regWrite;
	logic flagWrite;
	logic pcLoad;
	logic addSubtract;
	controlState_t state;
	instrClass_t opClass;
	logic instrDone;
	logic badInstr;
	logic [InstrWidth-1:0] pendingWord;
	int protocolErrors;
	integer seed;
	int cycleCount = 0;
	int testErrors;
	int totalErrors;
	int testsFailed;

	armControl DUT (
		.clk(clk), .reset(reset), .memData(memData), .moc(moc), .flags(flags),
		.memRequest(memRequest), .memWrite(memWrite), .memByte(memByte),
		.regWrite(regWrite), .flagWrite(flagWrite), .pcLoad(pcLoad),
		.addSubtract(addSubtract), .state(state), .opClass(opClass),
		.instrDone(instrDone), .badInstr(badInstr)
	);

	memoryResponder memory (
		.clk(clk), .reset(reset), .memRequest(memRequest), .state(state),
		.pendingWord(pendingWord), .memData(memData), .moc(moc),
		.protocolErrors(protocolErrors)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == TimeoutCycles) begin
			$display("Timeout after %0d cycles, the DUT stopped finishing instructions", cycleCount);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic expectEqual(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("[ERROR] %s = %h, expected %h (instruction %h)", name, got, want, pendingWord);
			testErrors++;
		end
	endtask

	// Odd codes invert the even one except AL and NV
	function automatic logic condHolds(logic [3:0] cond, logic [3:0] nzcv);
		logic base;
		case (cond[3:1])
			3'd0: base = nzcv[2];
			3'd1: base = nzcv[1];
			3'd2: base = nzcv[3];
			3'd3: base = nzcv[0];
			3'd4: base = nzcv[1] & ~nzcv[2];
			3'd5: base = (nzcv[3] == nzcv[0]);
			3'd6: base = ~nzcv[2] & (nzcv[3] == nzcv[0]);
			default: return ~cond[0];
		endcase
		return base ^ cond[0];
	endfunction

	function automatic instrClass_t classOf(logic [31:0] w);
		logic [2:0] cls;
		logic isTest;
		cls = w[ClassMsb:ClassLsb];
		isTest = (w[OpcodeMsb:OpcodeLsb] == opTst) || (w[OpcodeMsb:OpcodeLsb] == opTeq);
		if ((cls == 3'b000 && !w[ShiftRegBit]) || cls == 3'b001) begin
			return isTest ? classCompare : classDataProc;
		end
		if (cls == 3'b010 || (cls == 3'b011 && !w[ShiftRegBit])) begin
			return classLoadStore;
		end
		return (cls == 3'b101) ? classBranch : classUnsupported;
	endfunction

	function automatic string testName(int t);
		case (t)
			0: return "data processing";
			1: return "TST and TEQ";
			2: return "load and store";
			3: return "B and BL";
			4: return "random conditions";
			default: return "unsupported encodings";
		endcase
	endfunction

	task automatic buildWord(input int kind, output logic [31:0] word);
		logic [31:0] sel;
		int wordGroup;
		word = $random(seed);
		sel = $random(seed);
		wordGroup = (kind == 4) ? int'(sel[5:4]) : kind;	// Random conditions reuse groups 0 to 3
		word[CondMsb:CondLsb] = condAl;
		case (wordGroup)
			0, 1: begin
				word[ClassMsb:ClassLsb] = sel[0] ? 3'b001 : 3'b000;
				word[ShiftRegBit] = 1'b0;
				if (wordGroup == 1) begin
					word[OpcodeMsb:OpcodeLsb] = sel[1] ? opTeq : opTst;
				end else if (word[OpcodeMsb:OpcodeLsb] == opTst ||
					word[OpcodeMsb:OpcodeLsb] == opTeq) begin
					word[OpcodeMsb] = 1'b0;		// Turn a compare into AND or EOR
				end
			end
			2: begin
				word[ClassMsb:ClassLsb] = sel[0] ? 3'b011 : 3'b010;
				word[ShiftRegBit] = 1'b0;
			end
			3: word[ClassMsb:ClassLsb] = 3'b101;
			default: begin
				case ($unsigned(sel) % 6)
					0: {word[ClassMsb:ClassLsb], word[ExtraBit], word[ShiftRegBit]} = 5'b000_0_1;
					1: {word[ClassMsb:ClassLsb], word[ExtraBit], word[ShiftRegBit]} = 5'b000_1_1;
					2: {word[ClassMsb:ClassLsb], word[ShiftRegBit]} = 4'b011_1;
					3: word[ClassMsb:ClassLsb] = 3'b100;	// Block transfer
					4: word[ClassMsb:ClassLsb] = 3'b110;
					default: word[ClassMsb:ClassLsb] = 3'b111;
				endcase
			end
		endcase
		if (kind == 4) begin
			word[CondMsb:CondLsb] = sel[11:8];
		end
	endtask

	// Entered 2 ns after the edge that starts fetchAddress
	task automatic runInstruction(input logic [31:0] word);
		logic pass;
		logic expBad;
		logic expSub;
		logic subGot;
		logic sawWrite;
		logic sawByte;
		logic finished;
		instrClass_t expClass;
		int expReg;
		int expFlag;
		int expPc;
		int expData;
		int regWrites;
		int flagWrites;
		int pcLoads;
		int fetchReqs;
		int fetchWrites;
		int dataReqs;
		int dones;
		int bads;
		int regBeforePc;
		int strayAddSub;
		pendingWord = word;
		flags = 4'($random(seed));
		pass = condHolds(word[CondMsb:CondLsb], flags);
		expClass = classOf(word);
		expReg = 0;
		expFlag = 0;
		expPc = 0;
		expData = 0;
		if (pass) begin
			case (expClass)
				classDataProc: begin
					expReg = 1;
					expFlag = int'(word[LoadBit]);		// S bit
				end
				classCompare: expFlag = 1;
				classLoadStore: begin
					expReg = int'(word[LoadBit]) + int'(!word[PreIndexBit] || word[WriteBackBit]);
					expData = 1;
				end
				classBranch: begin
					expReg = int'(word[LinkBit]);
					expPc = 1;
				end
				default: ;
			endcase
		end
		expBad = pass && (expClass == classUnsupported);
		expSub = (expData == 1) && !word[UpBit];
		subGot = expSub;
		sawWrite = 1'b0;
		sawByte = 1'b0;
		regWrites = 0;
		flagWrites = 0;
		pcLoads = 0;
		fetchReqs = 0;
		fetchWrites = 0;
		dataReqs = 0;
		dones = 0;
		bads = 0;
		regBeforePc = -1;
		strayAddSub = 0;
		finished = 1'b0;
		while (!finished) begin
			@(negedge clk);
			if (memRequest) begin
				if (state == fetchIssue) begin
					fetchReqs++;
					fetchWrites += int'(memWrite);
				end else if (state == memIssue && fetchReqs > 0) begin
					dataReqs++;
					sawWrite = memWrite;
					sawByte = memByte;
				end else begin
					$display("memRequest raised outside an issue step or before the fetch, state %0d",
						state);
					testErrors++;
				end
			end
			if (state inside {addressCalc, memIssue, memWait, loadWriteBack, baseUpdate}) begin
				if (addSubtract != expSub) subGot = addSubtract;
			end else if (addSubtract) begin
				strayAddSub++;
			end
			if (pcLoad && regBeforePc < 0) regBeforePc = regWrites;
			regWrites += int'(regWrite);
			flagWrites += int'(flagWrite);
			pcLoads += int'(pcLoad);
			dones += int'(instrDone);
			bads += int'(badInstr);
			finished = instrDone || badInstr;
		end
		expectEqual("opClass", 32'(opClass), 32'(expClass));
		expectEqual("fetch memRequest", fetchReqs, 1);
		expectEqual("fetch memWrite", fetchWrites, 0);
		expectEqual("data memRequest", dataReqs, expData);
		expectEqual("regWrite", regWrites, expReg);
		expectEqual("flagWrite", flagWrites, expFlag);
		expectEqual("pcLoad", pcLoads, expPc);
		expectEqual("instrDone", dones, int'(!expBad));
		expectEqual("badInstr", bads, int'(expBad));
		expectEqual("addSubtract", 32'(subGot), 32'(expSub));
		expectEqual("addSubtract outside load/store", strayAddSub, 0);
		if (expData == 1) begin
			expectEqual("memWrite", 32'(sawWrite), 32'(!word[LoadBit]));
			expectEqual("memByte", 32'(sawByte), 32'(word[ByteBit]));
		end
		if (expPc == 1 && word[LinkBit]) begin
			expectEqual("regWrite before pcLoad", regBeforePc, 1);		// Link saved first
		end
		@(posedge clk);
		#2;
	endtask

	initial begin
		logic [31:0] word;
		seed = 32'hadb0_af3a;
		reset = 1'b1;
		flags = 4'h0;
		pendingWord = '0;
		totalErrors = 0;
		testsFailed = 0;
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int t = 0; t < NumTests; t++) begin
			testErrors = 0;
			for (int i = 0; i < InstrPerTest; i++) begin
				buildWord(t, word);
				runInstruction(word);
			end
			$display("Test %0d %s: %0d instructions, %0d errors", t + 1, testName(t),
				InstrPerTest, testErrors);
			totalErrors += testErrors;
			if (testErrors > 0) testsFailed++;
		end
		$display("Tests %0d, failed %0d, check errors %0d, protocol errors %0d", NumTests,
			testsFailed, totalErrors, protocolErrors);
		if (totalErrors == 0 && protocolErrors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* bench/memoryResponder.sv */
`timescale 1ns/10ps

module memoryResponder import controlPkg::*; (
	input	logic					clk,
	input	logic					reset,
	input	logic					memRequest,
	input	controlState_t			state,
	input	logic [InstrWidth-1:0]	pendingWord,
	output	logic [InstrWidth-1:0]	memData,
	output	logic					moc,
	output	int						protocolErrors
);

	integer seed;
	int delay;
	logic isFetch;
	logic lastRequest;
	logic waiting;		// Request seen, moc not yet returned

	initial begin
		seed = 32'hadb0_af3a;
		memData = '0;
		moc = 1'b0;
		forever begin
			@(negedge clk);
			if (!reset && memRequest) begin
				isFetch = (state == fetchIssue);
				delay = 1 + int'($unsigned($random(seed)) % 4);
				repeat (delay) @(posedge clk);
				#2;
				// Data reads return noise so a stray IR load would show up
				memData = isFetch ? pendingWord : $random(seed);
				moc = 1'b1;
				@(posedge clk);
				#2;
				moc = 1'b0;
			end
		end
	end

	// Bus protocol watch
	always @(negedge clk) begin
		if (reset) begin
			protocolErrors <= 0;
			lastRequest <= 1'b0;
			waiting <= 1'b0;
		end else begin
			lastRequest <= memRequest;
			if (memRequest && lastRequest) begin
				$display("memRequest stayed high for more than one cycle at %0t", $time);
				protocolErrors <= protocolErrors + 1;
			end
			if (memRequest && waiting) begin
				$display("New memRequest while an access was still pending at %0t", $time);
				protocolErrors <= protocolErrors + 1;
			end
			if (moc && !(state == fetchWait || state == memWait)) begin
				$display("moc returned while the sequencer was not waiting at %0t", $time);
				protocolErrors <= protocolErrors + 1;
			end
			if (memRequest) begin
				waiting <= 1'b1;
			end else if (moc) begin
				waiting <= 1'b0;
			end
		end
	end

endmodule

/* flist.f */
source/controlPkg.sv
source/conditionCheck.sv
source/instructionDecoder.sv
source/microSequencer.sv
source/armControl.sv
bench/memoryResponder.sv
bench/armControlBench.sv

/* run.sh */
#!/bin/bash
# Build and run the armControl testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f flist.f \
	--top-module armControlBench \
	-o simArmControl

./obj_dir/simArmControl | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
	echo "run.sh: testbench reported failure"
	exit 1
fi

echo "run.sh: no failure found in sim.log"
exit 0

/* source/armControl.sv */
`timescale 1ns/10ps

module armControl import controlPkg::*; (
	input	logic					clk,
	input	logic					reset,
	input	logic [InstrWidth-1:0]	memData,
	input	logic					moc,
	input	logic [3:0]				flags,
	output	logic					memRequest,
	output	logic					memWrite,
	output	logic					memByte,
	output	logic					regWrite,
	output	logic					flagWrite,
	output	logic					pcLoad,
	output	logic					addSubtract,
	output	controlState_t			state,
	output	instrClass_t			opClass,
	output	logic					instrDone,
	output	logic					badInstr
);

	logic irLoad;
	condCode_t condField;
	logic condPass;
	logic isLoad;
	logic isByte;
	logic isUp;
	logic writeBack;
	logic setFlags;
	logic isLink;

	instructionDecoder decoder (
		.clk		(clk),
		.reset		(reset),
		.irLoad		(irLoad),
		.memData	(memData),
		.condField	(condField),
		.opClass	(opClass),
		.isLoad		(isLoad),
		.isByte		(isByte),
		.isUp		(isUp),
		.writeBack	(writeBack),
		.setFlags	(setFlags),
		.isLink		(isLink)
	);

	conditionCheck condition (
		.condField	(condField),
		.flags		(flags),
		.condPass	(condPass)
	);

	microSequencer sequencer (
		.clk			(clk),
		.reset			(reset),
		.moc			(moc),
		.opClass		(opClass),
		.condPass		(condPass),
		.isLoad			(isLoad),
		.isByte			(isByte),
		.isUp			(isUp),
		.writeBack		(writeBack),
		.setFlags		(setFlags),
		.isLink			(isLink),
		.state			(state),
		.irLoad			(irLoad),
		.memRequest		(memRequest),
		.memWrite		(memWrite),
		.memByte		(memByte),
		.regWrite		(regWrite),
		.flagWrite		(flagWrite),
		.pcLoad			(pcLoad),
		.addSubtract	(addSubtract),
		.instrDone		(instrDone),
		.badInstr		(badInstr)
	);

endmodule

/* source/conditionCheck.sv */
`timescale 1ns/10ps

module conditionCheck import controlPkg::*; (
	input	condCode_t	condField,
	input	logic [3:0]	flags,		// NZCV
	output	logic		condPass
);

	logic n;
	logic z;
	logic c;
	logic v;

	assign n = flags[3];
	assign z = flags[2];
	assign c = flags[1];
	assign v = flags[0];

	always_comb begin
		case (condField)
			condEq: condPass = z;
			condNe: condPass = !z;
			condCs: condPass = c;
			condCc: condPass = !c;
			condMi: condPass = n;
			condPl: condPass = !n;
			condVs: condPass = v;
			condVc: condPass = !v;
			condHi: condPass = c && !z;			// Unsigned higher
			condLs: condPass = !c || z;
			condGe: condPass = (n == v);		// Signed compares
			condLt: condPass = (n != v);
			condGt: condPass = !z && (n == v);
			condLe: condPass = z || (n != v);
			condAl: condPass = 1'b1;
			default: condPass = 1'b0;			// condNv
		endcase
	end

endmodule

/* source/controlPkg.sv */
package controlPkg;

	localparam int InstrWidth = 32;

	// Instruction word fields
	localparam int CondMsb = 31;
	localparam int CondLsb = 28;
	localparam int ClassMsb = 27;
	localparam int ClassLsb = 25;
	localparam int OpcodeMsb = 24;
	localparam int OpcodeLsb = 21;

	// Single-bit fields
	localparam int PreIndexBit = 24;	// P
	localparam int UpBit = 23;			// U
	localparam int ByteBit = 22;		// B
	localparam int WriteBackBit = 21;	// W
	localparam int LoadBit = 20;		// L, also S for data processing
	localparam int LinkBit = 24;		// L of branch
	localparam int ShiftRegBit = 4;		// Shift by register or extra load/store
	localparam int ExtraBit = 7;		// Extra load/store when set with bit 4

	typedef enum logic [3:0] {
		fetchAddress,
		fetchIssue,
		fetchWait,
		decode,
		aluExecute,
		compareExecute,
		addressCalc,
		memIssue,
		memWait,
		loadWriteBack,
		baseUpdate,
		linkSave,
		branchExecute
	} controlState_t;

	typedef enum logic [2:0] {
		classDataProc,
		classCompare,
		classLoadStore,
		classBranch,
		classUnsupported
	} instrClass_t;

	typedef enum logic [3:0] {
		opAnd, opEor, opSub, opRsb,
		opAdd, opAdc, opSbc, opRsc,
		opTst, opTeq, opCmp, opCmn,
		opOrr, opMov, opBic, opMvn
	} dpOpcode_t;

	typedef enum logic [3:0] {
		condEq, condNe, condCs, condCc,
		condMi, condPl, condVs, condVc,
		condHi, condLs, condGe, condLt,
		condGt, condLe, condAl, condNv
	} condCode_t;

endpackage

/* source/instructionDecoder.sv */
`timescale 1ns/10ps

module instructionDecoder import controlPkg::*; (
	input	logic					clk,
	input	logic					reset,
	input	logic					irLoad,
	input	logic [InstrWidth-1:0]	memData,
	output	condCode_t				condField,
	output	instrClass_t			opClass,
	output	logic					isLoad,
	output	logic					isByte,
	output	logic					isUp,
	output	logic					writeBack,
	output	logic					setFlags,
	output	logic					isLink
);

	logic [InstrWidth-1:0] ir;
	logic irValid;			// Set once the first word is in
	logic [2:0] classBits;
	dpOpcode_t opcode;
	logic isTest;

	always_ff @(posedge clk) begin
		if (irLoad) begin
			ir <= memData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			irValid <= 1'b0;
		end else if (irLoad) begin
			irValid <= 1'b1;
		end
	end

	assign classBits = ir[ClassMsb:ClassLsb];
	assign opcode = dpOpcode_t'(ir[OpcodeMsb:OpcodeLsb]);
	assign isTest = (opcode == opTst) || (opcode == opTeq);	// Only these two are compares here

	always_comb begin
		case (classBits)
			3'b000: begin
				// Bit 4 high is shift by register or extra load/store
				if (!ir[ShiftRegBit]) begin
					opClass = isTest ? classCompare : classDataProc;
				end else begin
					opClass = classUnsupported;
				end
			end
			3'b001: opClass = isTest ? classCompare : classDataProc;	// Immediate operand
			3'b010: opClass = classLoadStore;							// Immediate offset
			3'b011: begin
				if (!ir[ShiftRegBit]) begin
					opClass = classLoadStore;							// Register offset
				end else begin
					opClass = classUnsupported;
				end
			end
			3'b101: opClass = classBranch;
			default: opClass = classUnsupported;	// Block transfer, coprocessor, SWI
		endcase
	end

	assign condField = condCode_t'(ir[CondMsb:CondLsb]);

	// Addressing attributes for load/store and branch
	assign isLoad = ir[LoadBit];
	assign isByte = ir[ByteBit];
	assign isUp = ir[UpBit];
	assign writeBack = !ir[PreIndexBit] || ir[WriteBackBit];	// Post-indexed always writes back
	assign setFlags = ir[LoadBit];
	assign isLink = ir[LinkBit];

	// Once a word has been loaded the class must be a legal value
	classKnown: assert property (@(posedge clk) disable iff (reset)
		irValid |-> !$isunknown(opClass));

endmodule

/* source/microSequencer.sv */
`timescale 1ns/10ps

module microSequencer import controlPkg::*; (
	input	logic			clk,
	input	logic			reset,
	input	logic			moc,
	input	instrClass_t	opClass,
	input	logic			condPass,
	input	logic			isLoad,
	input	logic			isByte,
	input	logic			isUp,
	input	logic			writeBack,
	input	logic			setFlags,
	input	logic			isLink,
	output	controlState_t	state,
	output	logic			irLoad,
	output	logic			memRequest,
	output	logic			memWrite,
	output	logic			memByte,
	output	logic			regWrite,
	output	logic			flagWrite,
	output	logic			pcLoad,
	output	logic			addSubtract,
	output	logic			instrDone,
	output	logic			badInstr
);

	controlState_t nextState;
	logic inLoadStore;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fetchAddress;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		case (state)
			fetchAddress: nextState = fetchIssue;
			fetchIssue: nextState = fetchWait;
			fetchWait: nextState = moc ? decode : fetchWait;
			decode: begin
				if (!condPass) begin
					nextState = fetchAddress;		// Skipped instruction
				end else begin
					case (opClass)
						classDataProc: nextState = aluExecute;
						classCompare: nextState = compareExecute;
						classLoadStore: nextState = addressCalc;
						classBranch: nextState = isLink ? linkSave : branchExecute;
						default: nextState = fetchAddress;
					endcase
				end
			end
			aluExecute: nextState = fetchAddress;
			compareExecute: nextState = fetchAddress;
			addressCalc: nextState = memIssue;
			memIssue: nextState = memWait;
			memWait: begin
				if (!moc) begin
					nextState = memWait;
				end else if (isLoad) begin
					nextState = loadWriteBack;
				end else begin
					nextState = writeBack ? baseUpdate : fetchAddress;
				end
			end
			loadWriteBack: nextState = writeBack ? baseUpdate : fetchAddress;
			baseUpdate: nextState = fetchAddress;
			linkSave: nextState = branchExecute;
			branchExecute: nextState = fetchAddress;
			default: nextState = fetchAddress;
		endcase
	end

	assign inLoadStore = (state == addressCalc) || (state == memIssue) ||
		(state == memWait) || (state == loadWriteBack) || (state == baseUpdate);

	assign irLoad = (state == fetchWait) && moc;
	assign memRequest = (state == fetchIssue) || (state == memIssue);
	assign memWrite = (state == memIssue) && !isLoad;
	assign memByte = (state == memIssue) && isByte;
	assign regWrite = (state == aluExecute) || (state == loadWriteBack) ||
		(state == baseUpdate) || (state == linkSave);
	assign flagWrite = ((state == aluExecute) && setFlags) || (state == compareExecute);
	assign pcLoad = (state == branchExecute);
	assign addSubtract = inLoadStore && !isUp;		// Down offset subtracts

	// Unsupported only counts when the condition passed
	assign badInstr = (state == decode) && condPass && (opClass == classUnsupported);
	// Last step of any instruction returns to fetch
	assign instrDone = (nextState == fetchAddress) && !badInstr;

	// A request is only raised from an issue step and always lands in a wait step
	requestThenWait: assert property (@(posedge clk) disable iff (reset)
		memRequest |-> (state == fetchIssue || state == memIssue)
			##1 (state == fetchWait || state == memWait));

	// Wait steps hold until memory completes
	waitHolds: assert property (@(posedge clk) disable iff (reset)
		((state == fetchWait || state == memWait) && !moc) |=> $stable(state));

	// A rejected instruction is not also completed and goes back to fetch
	badNotDone: assert property (@(posedge clk) disable iff (reset)
		badInstr |-> !instrDone ##1 (state == fetchAddress));

endmodule
